// File: rtl/umi_defs.svh
// umi merge widths and input count, shared by the package and every rtl block
`ifndef UMI_DEFS_SVH
`define UMI_DEFS_SVH

// ########################################
// umi field widths
// ########################################

`define UMI_DW 64 // data word
`define UMI_CW 32 // command word
`define UMI_AW 64 // address width, dst and src alike

// ########################################
// merge geometry
// ########################################

// inputs feeding the merge, order is {in1, in0}
`define UMI_NIN 2

`endif

// File: rtl/umi_pkg.sv
// umi merge types: field vectors, single-beat packet struct, arbiter hold states
`include "umi_defs.svh"

package umi_pkg;

   // ########################################
   // field vectors
   // ########################################

   typedef logic [`UMI_CW-1:0] umi_cmd_t;  // opcode, size, len etc
   typedef logic [`UMI_AW-1:0] umi_addr_t; // dst or src address
   typedef logic [`UMI_DW-1:0] umi_data_t; // one data word

   // one complete umi transfer, single beat
   typedef struct packed {
      umi_cmd_t  cmd;     // passed through, never decoded here
      umi_addr_t dstaddr; // where the request goes
      umi_addr_t srcaddr; // where a response would return
      umi_data_t data;    // payload word
   } umi_pkt_t;

   // arbiter hold fsm
   typedef enum logic {
      ARB_IDLE   = 1'b0, // free to pick a new source
      ARB_LOCKED = 1'b1  // granted packet stalled, sel frozen
   } arb_state_t;

endpackage

// File: rtl/umi_arbiter2.sv
// round-robin arbiter for the 2:1 umi merge, holds its grant while the output stalls
`timescale 1ns/1ps
`include "umi_defs.svh"

module umi_arbiter2
   import umi_pkg::*;
   (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [`UMI_NIN-1:0] in_valid,  // requests {in1, in0}
   input  logic                mux_valid, // merged valid after the mux
   input  logic                mux_ready, // slice can take a packet
   output logic                sel        // 1=in1, 0=in0
);

   arb_state_t state;       // idle or locked
   logic       prio;        // source that wins a tie
   logic       sel_hold;    // last grant, replayed while locked
   logic       pick;        // fresh round-robin choice
   logic       grant_done;  // granted packet moved this cycle
   logic       grant_stall; // granted packet waiting on the slice

   // ########################################
   // select
   // ########################################

   // tie goes to prio, otherwise whoever is asking
   // with no request at all this lands on in0, harmless since mux_valid is low
   assign pick = (in_valid[0] & in_valid[1]) ? prio : in_valid[1];

   // locked keeps ready routing steady until the stalled transfer finishes
   assign sel = (state == ARB_LOCKED) ? sel_hold : pick;

   assign grant_done  = mux_valid & mux_ready;
   assign grant_stall = mux_valid & ~mux_ready;

   // ########################################
   // priority and hold fsm
   // ########################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= ARB_IDLE;
         prio     <= 1'b0; // in0 first out of reset
         sel_hold <= 1'b0;
      end else begin
         sel_hold <= sel; // follows the live grant, frozen by the mux above

         case (state)
            ARB_IDLE: begin
               if (grant_stall) begin
                  state <= ARB_LOCKED; // slice full, pin the grant
               end
            end
            ARB_LOCKED: begin
               // sender keeps valid up, so only a transfer releases us
               if (!grant_stall) begin
                  state <= ARB_IDLE;
               end
            end
            default: begin
               state <= ARB_IDLE;
            end
         endcase

         // hand priority to the other side after each transfer
         if (grant_done) begin
            prio <= ~sel;
         end
      end
   end

endmodule

// File: rtl/umi_mux2.sv
// 2:1 umi packet mux steered by an external select, routes ready back to the inputs
`timescale 1ns/1ps
`include "umi_defs.svh"

module umi_mux2
   import umi_pkg::*;
   (
   input  logic                    sel,       // 1=in1, 0=in0
   // incoming umi, order {in1, in0}
   input  logic     [`UMI_NIN-1:0] in_valid,
   input  umi_pkt_t [`UMI_NIN-1:0] in_pkt,
   output logic     [`UMI_NIN-1:0] in_ready,
   // merged umi toward the slice
   output logic                    mux_valid,
   output umi_pkt_t                mux_pkt,
   input  logic                    mux_ready
);

   // ########################################
   // packet path
   // ########################################

   // whole struct in one go, cmd/addr/data stay together
   assign mux_pkt = sel ? in_pkt[1] : in_pkt[0];

   // ########################################
   // valid / ready
   // ########################################

   assign mux_valid = (sel & in_valid[1]) |
                      (~sel & in_valid[0]);

   // idle input always ready, busy one only when selected and downstream takes it
   assign in_ready[0] = ~in_valid[0] | (~sel & mux_ready);
   assign in_ready[1] = ~in_valid[1] | (sel & mux_ready);

endmodule

// File: rtl/umi_out_slice.sv
// two-entry skid slice on the merged umi stream, registered valid, packet and ready
`timescale 1ns/1ps
`include "umi_defs.svh"

module umi_out_slice
   import umi_pkg::*;
   (
   input  logic     clk,
   input  logic     rst_n,
   // from the mux
   input  logic     in_valid,
   input  umi_pkt_t in_pkt,
   output logic     in_ready,  // straight from a flop
   // to the merge output
   output logic     out_valid,
   output umi_pkt_t out_pkt,
   input  logic     out_ready
);

   logic     skid_valid; // second entry occupied
   umi_pkt_t skid_pkt;   // parked packet while main is stalled
   logic     in_fire;    // mux -> slice transfer
   logic     main_free;  // main register empty or draining this cycle
   logic     load_main;  // main takes the incoming packet
   logic     load_skid;  // skid takes the incoming packet

   assign in_fire   = in_valid & in_ready;
   assign main_free = ~out_valid | out_ready;

   // skid always drains into main first, so in_fire never coincides with skid_valid
   assign load_main = main_free & ~skid_valid & in_fire;
   assign load_skid = ~main_free & in_fire;

   // ########################################
   // occupancy and ready
   // ########################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
         in_ready   <= 1'b1; // both entries empty
      end else begin
         if (main_free) begin
            out_valid  <= skid_valid | in_fire; // refill from skid or input
            skid_valid <= 1'b0;
            in_ready   <= 1'b1; // at most one entry held next
         end else if (load_skid) begin
            skid_valid <= 1'b1;
            in_ready   <= 1'b0; // two held, push back on the mux
         end
      end
   end

   // ########################################
   // payload
   // ########################################

   always_ff @(posedge clk) begin
      if (main_free && skid_valid) begin
         out_pkt <= skid_pkt; // oldest first
      end else if (load_main) begin
         out_pkt <= in_pkt;
      end

      if (load_skid) begin
         skid_pkt <= in_pkt;
      end
   end

endmodule

// File: rtl/umi_mux2_arb.sv
// two-input umi merge, round-robin arbiter, 2:1 mux and output skid slice
`timescale 1ns/1ps
`include "umi_defs.svh"

module umi_mux2_arb
   import umi_pkg::*;
   (
   input  logic                    clk,
   input  logic                    rst_n,
   // umi inputs, order {in1, in0}
   input  logic     [`UMI_NIN-1:0] in_valid,
   input  umi_pkt_t [`UMI_NIN-1:0] in_pkt,
   output logic     [`UMI_NIN-1:0] in_ready,
   // merged umi output
   output logic                    out_valid,
   output umi_pkt_t                out_pkt,
   input  logic                    out_ready
);

   logic     sel;       // arbiter grant
   logic     mux_valid;
   umi_pkt_t mux_pkt;
   logic     mux_ready; // registered, from the slice

   // ########################################
   // arbitration
   // ########################################

   umi_arbiter2 arbiter_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .mux_valid (mux_valid), // watches for grant completion
      .mux_ready (mux_ready),
      .sel       (sel)
   );

   umi_mux2 mux_inst (
      .sel       (sel),
      .in_valid  (in_valid),
      .in_pkt    (in_pkt),
      .in_ready  (in_ready),
      .mux_valid (mux_valid),
      .mux_pkt   (mux_pkt),
      .mux_ready (mux_ready)
   );

   // ########################################
   // output register slice
   // ########################################

   umi_out_slice slice_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (mux_valid),
      .in_pkt    (mux_pkt),
      .in_ready  (mux_ready),
      .out_valid (out_valid),
      .out_pkt   (out_pkt),
      .out_ready (out_ready)
   );

endmodule

// File: tb/umi_mux2_arb_props.sv
// bound checks on the merge: reset state, output hold, grant hold, slice fill
`timescale 1ns/1ps
`include "umi_defs.svh"

module umi_mux2_arb_props
   import umi_pkg::*;
   (
   input logic     clk,
   input logic     rst_n,
   input logic     out_valid,
   input umi_pkt_t out_pkt,
   input logic     out_ready,
   input logic     mux_valid, // internal, from the mux
   input logic     mux_ready, // internal, slice ready
   input logic     sel        // internal, arbiter grant
);

   int unsigned fail_count = 0; // watched from the testbench

   // ########################################
   // properties
   // ########################################

   // first cycle out of reset, nothing on the output
   a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
      else begin
         fail_count++;
         $error("CHECK FAILED at %0t ns: out_valid high right after reset", $time);
      end

   // stalled output keeps valid and packet
   a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_pkt))
      else begin
         fail_count++;
         $error("CHECK FAILED at %0t ns: output changed while stalled", $time);
      end

   a_sel_hold: assert property (@(posedge clk) disable iff (!rst_n)
      mux_valid && !mux_ready |=> $stable(sel)) // grant frozen while locked
      else begin
         fail_count++;
         $error("CHECK FAILED at %0t ns: select moved during a stall", $time);
      end

   // slice only refuses when it already holds an output
   a_full_valid: assert property (@(posedge clk) disable iff (!rst_n)
      !mux_ready |-> out_valid)
      else begin
         fail_count++;
         $error("CHECK FAILED at %0t ns: slice not ready with no output", $time);
      end

endmodule

bind umi_mux2_arb umi_mux2_arb_props props_inst (
   .clk       (clk),
   .rst_n     (rst_n),
   .out_valid (out_valid),
   .out_pkt   (out_pkt),
   .out_ready (out_ready),
   .mux_valid (mux_valid),
   .mux_ready (mux_ready),
   .sel       (sel)
);

// File: tb/umi_mux2_arb_tb.sv
// testbench for the 2:1 umi merge, random traffic, fairness phase, drain and counts
`timescale 1ns/1ps
`include "umi_defs.svh"

module umi_mux2_arb_tb
   import umi_pkg::*;
   ;

   localparam int RAND_PKTS      = 1200;                  // per input, random gaps
   localparam int FAIR_PKTS      = 300;                   // per input, back to back
   localparam int TOTAL_PKTS     = `UMI_NIN * (RAND_PKTS + FAIR_PKTS);
   localparam int TIMEOUT_CYCLES = TOTAL_PKTS * 4;
   localparam int PH_RAND        = 0;
   localparam int PH_FAIR        = 1;
   localparam int PH_DRAIN       = 2;

   logic                    clk;
   logic                    rst_n;
   logic     [`UMI_NIN-1:0] in_valid = '0;
   umi_pkt_t [`UMI_NIN-1:0] in_pkt = '0;
   logic     [`UMI_NIN-1:0] in_ready;
   logic                    out_valid;
   umi_pkt_t                out_pkt;
   logic                    out_ready = 1'b0;

   integer   seed = 32'h603d_e357;
   int       phase = PH_RAND;
   int       sent[`UMI_NIN];    // packets offered per input
   int       acc_cnt[`UMI_NIN]; // transfers taken by the dut
   int       out_cnt[`UMI_NIN]; // packets seen on the output, by srcaddr
   int       gap[`UMI_NIN];     // idle cycles left before the next offer
   int       last_src;          // source of the previous fair-phase output
   int       fair_seen = 0;
   umi_pkt_t offered[`UMI_NIN][RAND_PKTS + FAIR_PKTS]; // every packet offered, by seq

   umi_mux2_arb umi_mux2_arb_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_pkt    (in_pkt),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_pkt   (out_pkt),
      .out_ready (out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk; // 8 ns period
   end

   // ########################################
   // helpers
   // ########################################

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Test failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_mismatch(input string what);
      stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s", $time, what));
   endtask

   function automatic int quota_for(input int ph);
      return (ph == PH_RAND) ? RAND_PKTS : RAND_PKTS + FAIR_PKTS;
   endfunction

   function automatic umi_pkt_t make_pkt(input int idx, input int seq);
      umi_pkt_t pkt;
      pkt.cmd     = $random(seed);                   // opaque to the merge
      pkt.dstaddr = {$random(seed), $random(seed)};
      pkt.srcaddr = umi_addr_t'(idx);                // source tag
      pkt.data    = umi_data_t'(seq);                // per-input sequence
      return pkt;
   endfunction

   // ########################################
   // stimulus
   // ########################################

   always @(posedge clk) begin
      if (rst_n) begin
         for (int i = 0; i < `UMI_NIN; i++) begin
            if (!in_valid[i] || in_ready[i]) begin // idle, or transfer this edge
               if (in_valid[i]) begin
                  acc_cnt[i]++;
               end
               if (sent[i] < quota_for(phase) && (phase != PH_RAND || gap[i] == 0)) begin
                  offered[i][sent[i]] = make_pkt(i, sent[i]);
                  in_valid[i] <= 1'b1;
                  in_pkt[i]   <= offered[i][sent[i]];
                  sent[i]++;
                  gap[i] = $random(seed) & 3; // 0..3 idle cycles after this one
               end else begin
                  in_valid[i] <= 1'b0;
                  if (gap[i] > 0) begin
                     gap[i]--;
                  end
               end
            end
         end
      end
   end

   // back-pressure only in the random phase
   always @(posedge clk) begin
      out_ready <= (phase == PH_RAND) ? (($random(seed) & 3) != 0) : 1'b1;
   end

   // ########################################
   // output monitor
   // ########################################

   always @(posedge clk) begin
      int src;
      if (rst_n && out_valid && out_ready) begin
         assert (out_pkt.srcaddr < umi_addr_t'(`UMI_NIN))
            else report_mismatch("output srcaddr names no input");
         src = out_pkt.srcaddr[0] ? 1 : 0;
         assert (out_pkt.data == umi_data_t'(out_cnt[src]))
            else report_mismatch($sformatf("input %0d got seq %0d, expected %0d",
                                           src, out_pkt.data, out_cnt[src]));
         assert (out_pkt == offered[src][out_cnt[src]])
            else report_mismatch($sformatf("input %0d seq %0d cmd or dstaddr corrupted",
                                           src, out_cnt[src]));
         out_cnt[src]++;
         if (out_pkt.data >= umi_data_t'(RAND_PKTS)) begin // fair-phase packet
            if (fair_seen > 0) begin
               assert (src != last_src)
                  else report_mismatch("fair phase output did not alternate sources");
            end
            last_src = src;
            fair_seen++;
         end
      end
   end

   // stop once any bound property has fired
   always @(posedge clk) begin
      if (umi_mux2_arb_inst.props_inst.fail_count != 0) begin
         stop_with_failure("a bound assertion on the merge fired");
      end
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      stop_with_failure("watchdog expired before the merge drained");
   end

   // ########################################
   // phase sequencing
   // ########################################

   initial begin
      for (int i = 0; i < `UMI_NIN; i++) begin
         sent[i]    = 0;
         acc_cnt[i] = 0;
         out_cnt[i] = 0;
         gap[i]     = 0;
      end
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      // settled values only, checked away from the active edge
      @(negedge clk);
      while (!(sent[0] == RAND_PKTS && sent[1] == RAND_PKTS && in_valid == '0)) begin
         @(negedge clk);
      end
      @(posedge clk);
      phase <= PH_FAIR; // both inputs start together next edge

      @(negedge clk);
      while (!(sent[0] == quota_for(PH_FAIR) && sent[1] == quota_for(PH_FAIR) &&
               in_valid == '0)) begin
         @(negedge clk);
      end
      @(posedge clk);
      phase <= PH_DRAIN;

      @(negedge clk);
      while (out_valid) begin // slice empties with out_ready high
         @(negedge clk);
      end

      for (int i = 0; i < `UMI_NIN; i++) begin
         assert (out_cnt[i] == acc_cnt[i] && acc_cnt[i] == RAND_PKTS + FAIR_PKTS)
            else report_mismatch($sformatf("input %0d accepted %0d, delivered %0d",
                                           i, acc_cnt[i], out_cnt[i]));
      end
      assert (fair_seen == `UMI_NIN * FAIR_PKTS)
         else report_mismatch("fair phase packet count is off");

      if (umi_mux2_arb_inst.props_inst.fail_count == 0) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         stop_with_failure("a bound assertion fired before the end of the run");
      end
   end

endmodule

// File: files.f
+incdir+rtl
rtl/umi_pkg.sv
rtl/umi_arbiter2.sv
rtl/umi_mux2.sv
rtl/umi_out_slice.sv
rtl/umi_mux2_arb.sv
tb/umi_mux2_arb_props.sv
tb/umi_mux2_arb_tb.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := umi_mux2_arb_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
RUN_FLAGS := +verilator+error+limit+100
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
